// File: rtl/cacheController.sv
// one transaction at a time; the DRAM must give word 0 of the line exactly two cycles after the read CAS
`timescale 1ns/1ps
`include "cacheDefines.svh"

module cacheController (
	input logic Clock,
	input logic Reset_L,
	// cpu side
	input logic [31:0] cpuAddress,
	input cachePkg::dataWord cpuDataIn,
	input logic cpuAsL,
	input logic cpuWeL,
	input logic cpuUdsL,
	input logic cpuLdsL,
	input logic cpuSelect, // address decodes to DRAM
	output cachePkg::dataWord cpuDataOut,
	output logic cpuDtackL,
	// dram side
	output logic dramSelectL,
	output logic [31:0] dramAddress,
	output logic dramWeL,
	output logic dramUdsL,
	output logic dramLdsL,
	output cachePkg::dataWord dramDataOut,
	input logic dramDtackL,
	input logic dramCasL,
	input logic dramRasL, // low with CAS means refresh
	input cachePkg::dataWord dramReadData,
	// store side
	output logic [`INDEX_BITS-1:0] setIndex,
	output logic [`WORD_BITS-1:0] wordIndex,
	output cachePkg::tagEntry tagWrite,
	output cachePkg::wayMask tagWeL,
	input cachePkg::tagEntry tagRead [`CACHE_WAYS],
	output cachePkg::dataWord dataWrite,
	output cachePkg::wayMask dataWeL,
	input cachePkg::dataWord dataRead [`CACHE_WAYS],
	output cachePkg::plruBits lruWrite,
	output cachePkg::wayMask lruWeL, // only way 0 holds LRU state
	input cachePkg::plruBits lruRead
);

	cachePkg::ctrlState state, nextState;
	logic [`WORD_BITS:0] count; // sweep set or burst word, one bit spare to reach 8
	logic [1:0] victimReg; // way being filled
	logic [1:0] victimWay;
	cachePkg::wayMask victimMask;
	cachePkg::wayMask hitMask; // valid and tag match per way
	cachePkg::plruBits plruNext;
	logic [`TAG_BITS-1:0] cpuTag;

	assign cpuTag = cpuAddress[31 -: `TAG_BITS];
	assign victimMask = cachePkg::wayMask'(1) << victimReg;

	////////////////////////////////
	// tag compare and hit data
	////////////////////////////////

	always_comb begin
		cpuDataOut = '0;
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			hitMask[w] = tagRead[w].valid && (tagRead[w].tag == cpuTag);
			if (hitMask[w]) begin
				cpuDataOut = dataRead[w]; // after a fill the victim hits too
			end
		end
	end

	plruPolicy uPlru (
		.state(lruRead),
		.hitWay(hitMask),
		.isHit(|hitMask),
		.victimWay(victimWay),
		.nextState(plruNext)
	);

	////////////////////////////////
	// state, counter and victim registers
	////////////////////////////////

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			state <= cachePkg::Reset;
			count <= '0;
			victimReg <= '0;
		end else begin
			state <= nextState;
			// counts only while sweeping or filling, so CasWait2 leaves it at 0
			if (state == cachePkg::Invalidate || state == cachePkg::BurstFill) begin
				count <= count + 1'b1;
			end else begin
				count <= '0;
			end
			if (state == cachePkg::Lookup) begin
				victimReg <= victimWay; // unused on a hit
			end
		end
	end

	assign dramDataOut = cpuDataIn; // write data goes straight through
	assign dataWrite = dramReadData; // burst words into the victim way

	////////////////////////////////
	// next state and outputs
	////////////////////////////////

	always_comb begin
		nextState = state;
		setIndex = cpuAddress[`WORD_BITS+1 +: `INDEX_BITS];
		wordIndex = cpuAddress[1 +: `WORD_BITS];
		cpuDtackL = 1'b1;
		dramSelectL = 1'b1;
		dramAddress = {cpuAddress[31:`WORD_BITS+1], {(`WORD_BITS+1){1'b0}}}; // line aligned
		dramWeL = 1'b1;
		dramUdsL = 1'b1;
		dramLdsL = 1'b1;
		tagWrite.valid = 1'b0;
		tagWrite.tag = cpuTag;
		tagWeL = '1;
		dataWeL = '1;
		lruWrite = plruNext;
		lruWeL = '1;

		case (state)
			cachePkg::Reset: begin
				nextState = cachePkg::Invalidate;
			end
			cachePkg::Invalidate: begin
				setIndex = count[`INDEX_BITS-1:0];
				tagWrite.tag = '0;
				tagWeL = '0; // all ways of the set
				lruWrite = '0;
				lruWeL = 4'b1110;
				if (count == `CACHE_SETS - 1) begin
					nextState = cachePkg::Idle;
				end
			end
			cachePkg::Idle: begin
				if (!cpuAsL && cpuSelect) begin
					nextState = cpuWeL ? cachePkg::Lookup : cachePkg::WriteThrough;
				end
			end
			cachePkg::Lookup: begin
				lruWeL = 4'b1110; // hit way or victim becomes most recent
				nextState = (|hitMask) ? cachePkg::HoldRead : cachePkg::AwaitCas;
			end
			cachePkg::AwaitCas: begin
				dramSelectL = 1'b0;
				dramUdsL = 1'b0;
				dramLdsL = 1'b0;
				tagWrite.valid = 1'b1; // claim the victim while DRAM gets going
				tagWeL = ~victimMask;
				if (!dramCasL && dramRasL) begin
					nextState = cachePkg::CasWait1; // read CAS, not a refresh
				end
			end
			cachePkg::CasWait1, cachePkg::CasWait2: begin
				dramSelectL = 1'b0;
				dramUdsL = 1'b0;
				dramLdsL = 1'b0;
				nextState = (state == cachePkg::CasWait1) ? cachePkg::CasWait2 : cachePkg::BurstFill;
			end
			cachePkg::BurstFill: begin
				dramSelectL = 1'b0;
				dramUdsL = 1'b0;
				dramLdsL = 1'b0;
				wordIndex = count[`WORD_BITS-1:0];
				if (count == `LINE_WORDS) begin
					nextState = cachePkg::HoldRead; // one spare cycle like the original
				end else begin
					dataWeL = ~victimMask;
				end
			end
			cachePkg::HoldRead: begin
				cpuDtackL = 1'b0; // data valid from the hitting way
				if (cpuAsL) begin
					nextState = cachePkg::Idle;
				end
			end
			cachePkg::WriteThrough: begin
				dramSelectL = 1'b0;
				dramAddress = cpuAddress;
				dramWeL = 1'b0;
				dramUdsL = cpuUdsL;
				dramLdsL = cpuLdsL;
				tagWeL = ~hitMask; // drop a stale line, valid stays 0
				cpuDtackL = dramDtackL;
				if (cpuAsL) begin
					nextState = cachePkg::Idle;
				end
			end
			default: begin
				nextState = cachePkg::Reset;
			end
		endcase
	end

endmodule

// File: rtl/cacheDefines.svh
// sizes are fixed for a 16-bit 68000 data bus with a 32-bit byte address; tag + index + word + 1 must equal 32
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

////////////////////////////////
// cache geometry
////////////////////////////////

`define CACHE_WAYS 4 // four-way set associative
`define CACHE_SETS 8 // sets selected by address bits 6:4
`define LINE_WORDS 8 // 16-bit words per line, also the DRAM burst length

////////////////////////////////
// address split
////////////////////////////////

`define TAG_BITS 25 // address bits 31:7
`define INDEX_BITS 3 // log2 of CACHE_SETS
`define WORD_BITS 3 // log2 of LINE_WORDS, address bit 0 is the byte lane

////////////////////////////////
// DRAM timing
////////////////////////////////

`define CAS_LATENCY 2 // cycles from the read CAS edge to burst word 0

`endif

// File: rtl/cachePkg.sv
// shared types for the read cache; tag width comes from the defines header and must match the address split
`include "cacheDefines.svh"

package cachePkg;

	// one tag store entry, valid sits above the tag
	typedef struct packed {
		logic valid; // line holds DRAM data
		logic [`TAG_BITS-1:0] tag; // cpu address bits 31:7
	} tagEntry;

	typedef logic [15:0] dataWord; // one cached 16-bit word

	// tree pseudo-LRU state of a set
	// bit 0: 0 = ways 0/1 older, 1 = ways 2/3 older
	// bit 1: 0 = way 0 older than way 1
	// bit 2: 0 = way 2 older than way 3
	typedef logic [2:0] plruBits;

	typedef logic [`CACHE_WAYS-1:0] wayMask; // one bit per way

	typedef enum logic [3:0] {
		Reset, // one cycle, clears the sweep counter
		Invalidate, // clears tag, valid and LRU of one set per cycle
		Idle, // waits for a cpu strobe to DRAM space
		Lookup, // tag compare and LRU update
		AwaitCas, // miss, DRAM selected until a read CAS shows up
		CasWait1, // first CAS latency cycle
		CasWait2, // second CAS latency cycle
		BurstFill, // eight words into the victim way
		HoldRead, // dtack to the cpu until it drops the strobe
		WriteThrough // write passed to DRAM, hit line invalidated
	} ctrlState;

endpackage

// File: rtl/cacheStore.sv
// storage has no reset, contents are only meaningful after the controller sweep; reads are asynchronous
`timescale 1ns/1ps
`include "cacheDefines.svh"

module cacheStore #(
	parameter type payloadType = logic [15:0], // entry type held per way
	parameter int depth = 8 // entries per way
) (
	input logic Clock,
	input logic [$clog2(depth)-1:0] address, // shared by all ways
	input cachePkg::wayMask writeEnableL, // active low, one per way
	input payloadType writeData, // same payload offered to every way
	output payloadType readData [`CACHE_WAYS] // one entry per way at address
);

	////////////////////////////////
	// one array per way
	////////////////////////////////

	payloadType mem [`CACHE_WAYS][depth]; // way-major storage

	for (genvar w = 0; w < `CACHE_WAYS; w++) begin : gWay
		// synchronous write of the selected way
		always_ff @(posedge Clock) begin
			if (!writeEnableL[w]) begin
				mem[w][address] <= writeData; // lands at the end of the cycle
			end
		end

		// combinational read so the controller sees the entry in the same cycle
		assign readData[w] = mem[w][address];
	end

	// several ways may be written at once, the invalidate sweep
	// relies on that to clear a whole set per cycle

endmodule

// File: rtl/m68kCacheTop.sv
// read cache for a 68000 bus in front of a burst DRAM controller; writes always go through to DRAM
`timescale 1ns/1ps
`include "cacheDefines.svh"

module m68kCacheTop (
	input logic Clock,
	input logic Reset_L,
	// cpu bus
	input logic [31:0] cpuAddress,
	input cachePkg::dataWord cpuDataIn,
	input logic cpuAsL,
	input logic cpuWeL,
	input logic cpuUdsL,
	input logic cpuLdsL,
	input logic cpuSelect,
	output cachePkg::dataWord cpuDataOut,
	output logic cpuDtackL,
	// dram bus
	output logic dramSelectL,
	output logic [31:0] dramAddress,
	output logic dramWeL,
	output logic dramUdsL,
	output logic dramLdsL,
	output cachePkg::dataWord dramDataOut,
	input logic dramDtackL,
	input logic dramCasL,
	input logic dramRasL,
	input cachePkg::dataWord dramReadData
);

	logic [`INDEX_BITS-1:0] setIndex;
	logic [`WORD_BITS-1:0] wordIndex;
	cachePkg::tagEntry tagWrite;
	cachePkg::wayMask tagWeL;
	cachePkg::tagEntry tagWays [`CACHE_WAYS];
	cachePkg::dataWord dataWrite;
	cachePkg::wayMask dataWeL;
	cachePkg::dataWord dataWays [`CACHE_WAYS];
	cachePkg::plruBits lruWrite;
	cachePkg::wayMask lruWeL;
	cachePkg::plruBits lruWays [`CACHE_WAYS]; // only way 0 is ever written

	cacheController uController (
		.Clock, .Reset_L,
		.cpuAddress, .cpuDataIn, .cpuAsL, .cpuWeL, .cpuUdsL, .cpuLdsL, .cpuSelect,
		.cpuDataOut, .cpuDtackL,
		.dramSelectL, .dramAddress, .dramWeL, .dramUdsL, .dramLdsL, .dramDataOut,
		.dramDtackL, .dramCasL, .dramRasL, .dramReadData,
		.setIndex, .wordIndex,
		.tagWrite, .tagWeL, .tagRead(tagWays),
		.dataWrite, .dataWeL, .dataRead(dataWays),
		.lruWrite, .lruWeL, .lruRead(lruWays[0])
	);

	////////////////////////////////
	// private memories
	////////////////////////////////

	cacheStore #(.payloadType(cachePkg::tagEntry), .depth(`CACHE_SETS)) tagStore (
		.Clock, .address(setIndex), .writeEnableL(tagWeL),
		.writeData(tagWrite), .readData(tagWays)
	);

	// word store addressed by set then word
	cacheStore #(.payloadType(cachePkg::dataWord), .depth(`CACHE_SETS * `LINE_WORDS)) dataStore (
		.Clock, .address({setIndex, wordIndex}), .writeEnableL(dataWeL),
		.writeData(dataWrite), .readData(dataWays)
	);

	cacheStore #(.payloadType(cachePkg::plruBits), .depth(`CACHE_SETS)) lruStore (
		.Clock, .address(setIndex), .writeEnableL(lruWeL),
		.writeData(lruWrite), .readData(lruWays)
	);

endmodule

// File: rtl/plruPolicy.sv
// four-way tree pseudo-LRU only; with several hit bits set the lowest way is taken as the hit
`timescale 1ns/1ps
`include "cacheDefines.svh"

module plruPolicy (
	input cachePkg::plruBits state, // current tree of the set
	input cachePkg::wayMask hitWay, // one-hot on a hit
	input logic isHit, // touch the hit way, else the victim
	output logic [1:0] victimWay, // oldest way by the tree
	output cachePkg::plruBits nextState // tree after the touch
);

	logic [1:0] hitIndex; // encoded hit way
	logic [1:0] touchedWay; // way made most recent

	// one-hot to index, lowest way wins
	always_comb begin
		hitIndex = 2'd0;
		for (int w = `CACHE_WAYS - 1; w >= 0; w--) begin
			if (hitWay[w]) begin
				hitIndex = 2'(w);
			end
		end
	end

	// follow the older branch down the tree
	assign victimWay = state[0] ? {1'b1, state[2]} : {1'b0, state[1]};

	assign touchedWay = isHit ? hitIndex : victimWay;

	////////////////////////////////
	// point the tree away from the touched way
	////////////////////////////////

	always_comb begin
		case (touchedWay)
			2'd0: nextState = {state[2], 2'b11}; // pair 2/3 older, way 1 older
			2'd1: nextState = {state[2], 2'b01}; // pair 2/3 older, way 0 older
			2'd2: nextState = {1'b1, state[1], 1'b0}; // pair 0/1 older, way 3 older
			default: nextState = {1'b0, state[1], 1'b0}; // pair 0/1 older, way 2 older
		endcase
	end

endmodule

// File: sim.f
+incdir+rtl
rtl/cachePkg.sv
rtl/cacheStore.sv
rtl/plruPolicy.sv
rtl/cacheController.sv
rtl/m68kCacheTop.sv
testbench/cacheChecker.sv
testbench/cacheTop_props.sv
testbench/cacheTb.sv

// File: testbench/cacheChecker.sv
// reference model of the cache seen from its buses; addresses must stay below 0x2000, one transaction at a time
`timescale 1ns/1ps
`include "cacheDefines.svh"

module cacheChecker (
	input logic Clock,
	input logic Reset_L,
	input logic [31:0] cpuAddress,
	input logic [15:0] cpuDataIn,
	input logic cpuAsL,
	input logic cpuWeL,
	input logic cpuUdsL,
	input logic cpuLdsL,
	input logic [15:0] cpuDataOut,
	input logic cpuDtackL,
	input logic dramSelectL,
	input logic [31:0] dramAddress,
	input logic dramWeL,
	input logic dramUdsL,
	input logic dramLdsL,
	input logic [15:0] dramDataOut,
	input logic [15:0] dramImage [4096], // initial DRAM contents, copied during reset
	output int errorCount,
	output int checkCount
);

	logic [15:0] refMem [4096]; // expected DRAM, word addressed
	logic refValid [`CACHE_SETS][`CACHE_WAYS];
	logic [`TAG_BITS-1:0] refTag [`CACHE_SETS][`CACHE_WAYS];
	logic [2:0] refLru [`CACHE_SETS]; // tree state per set
	logic usedDram; // dramSelectL seen low in this access
	logic answered; // dtack already checked
	logic expHit;
	logic [15:0] expData;
	int lastChecks = 0;
	int lastErrors = 0;

	////////////////////////////////
	// pLRU tree rules
	////////////////////////////////

	function automatic int oldestWay(input logic [2:0] lru);
		if (!lru[0]) begin
			return lru[1] ? 1 : 0; // pair 0/1 is older
		end
		return lru[2] ? 3 : 2;
	endfunction

	function automatic logic [2:0] touchWay(input logic [2:0] lru, input int way);
		logic [2:0] tree;
		tree = lru;
		case (way)
			0: tree[1:0] = 2'b11;
			1: tree[1:0] = 2'b01;
			2: begin
				tree[0] = 1'b0;
				tree[2] = 1'b1;
			end
			default: begin
				tree[0] = 1'b0;
				tree[2] = 1'b0;
			end
		endcase
		return tree;
	endfunction

	// updates the model for one access, returns the expected hit and the word read back
	function automatic logic predictAccess(input logic [31:0] addr, input logic isWrite,
		input logic [15:0] wData, input logic udsL, input logic ldsL, output logic [15:0] rData);
		int set;
		int wordAddr;
		int hitWay;
		int way;
		int w;
		set = addr[6:4];
		wordAddr = addr[12:1];
		hitWay = -1;
		for (w = 0; w < `CACHE_WAYS; w++) begin
			if (refValid[set][w] && refTag[set][w] == addr[31:7]) begin
				hitWay = w;
			end
		end
		if (isWrite) begin
			if (!udsL) refMem[wordAddr][15:8] = wData[15:8];
			if (!ldsL) refMem[wordAddr][7:0] = wData[7:0];
			if (hitWay >= 0) refValid[set][hitWay] = 1'b0; // stale line dropped, LRU untouched
		end else begin
			way = (hitWay >= 0) ? hitWay : oldestWay(refLru[set]);
			refValid[set][way] = 1'b1;
			refTag[set][way] = addr[31:7];
			refLru[set] = touchWay(refLru[set], way);
		end
		rData = refMem[wordAddr];
		return hitWay >= 0;
	endfunction

	////////////////////////////////
	// compare at dtack
	////////////////////////////////

	always @(negedge Clock) begin
		int s;
		int w;
		if (!Reset_L) begin
			for (s = 0; s < `CACHE_SETS; s++) begin
				refLru[s] = 3'b000;
				for (w = 0; w < `CACHE_WAYS; w++) refValid[s][w] = 1'b0;
			end
			for (s = 0; s < 4096; s++) refMem[s] = dramImage[s];
			usedDram = 1'b0;
			answered = 1'b0;
			errorCount = 0;
			checkCount = 0;
		end else if (cpuAsL) begin
			usedDram = 1'b0; // bus idle, next access starts clean
			answered = 1'b0;
		end else begin
			if (!dramSelectL) usedDram = 1'b1;
			if (!cpuDtackL && !answered) begin
				answered = 1'b1;
				checkCount++;
				expHit = predictAccess(cpuAddress, !cpuWeL, cpuDataIn, cpuUdsL, cpuLdsL, expData);
				if (cpuWeL && cpuDataOut !== expData) begin
					errorCount++;
					$display("MISMATCH at %0t: read %h returned %h, expected %h",
						$time, cpuAddress, cpuDataOut, expData);
				end else if (cpuWeL && usedDram == expHit) begin
					errorCount++;
					$display("MISMATCH at %0t: read %h was a %s, expected a %s", $time, cpuAddress,
						usedDram ? "miss" : "hit", expHit ? "hit" : "miss");
				end else if (!cpuWeL && (dramAddress !== cpuAddress || dramWeL !== 1'b0 ||
					dramUdsL !== cpuUdsL || dramLdsL !== cpuLdsL || dramDataOut !== cpuDataIn)) begin
					errorCount++;
					$display("MISMATCH at %0t: write %h reached DRAM as %h data %h strobes %b%b",
						$time, cpuAddress, dramAddress, dramDataOut, dramUdsL, dramLdsL);
				end
			end
		end
	end

	// one line per finished test, counts since the previous call
	task finishTest(input int number, input string name);
		$display("test %0d, %s: %0d checks, %0d errors", number, name,
			checkCount - lastChecks, errorCount - lastErrors);
		lastChecks = checkCount;
		lastErrors = errorCount;
	endtask

endmodule

// File: testbench/cacheTb.sv
// DRAM model holds 4096 words so test addresses stay below 0x2000; needs a simulator with bind support
`timescale 1ns/1ps
`include "cacheDefines.svh"

module cacheTb;

	localparam int transactionCount = 8 + 16 + 4 + 20 + 40; // tests 1 to 5
	localparam int cycleLimit = 60 * transactionCount + 4 + 1 + `CACHE_SETS + 1;

	logic Clock = 1'b0;
	logic Reset_L;
	logic [31:0] cpuAddress;
	logic [15:0] cpuDataIn;
	logic cpuAsL, cpuWeL, cpuUdsL, cpuLdsL, cpuSelect;
	logic [15:0] cpuDataOut;
	logic cpuDtackL;
	logic dramSelectL;
	logic [31:0] dramAddress;
	logic dramWeL, dramUdsL, dramLdsL;
	logic [15:0] dramDataOut;
	logic dramDtackL, dramCasL, dramRasL;
	logic [15:0] dramReadData;
	logic [15:0] dramMem [4096]; // word addressed by bits 12:1
	integer seed = 32'h151e;
	int cycleCount = 0;
	int errorCount, checkCount;

	m68kCacheTop uut (
		.Clock, .Reset_L,
		.cpuAddress, .cpuDataIn, .cpuAsL, .cpuWeL, .cpuUdsL, .cpuLdsL, .cpuSelect,
		.cpuDataOut, .cpuDtackL,
		.dramSelectL, .dramAddress, .dramWeL, .dramUdsL, .dramLdsL, .dramDataOut,
		.dramDtackL, .dramCasL, .dramRasL, .dramReadData
	);

	cacheChecker check (
		.Clock, .Reset_L,
		.cpuAddress, .cpuDataIn, .cpuAsL, .cpuWeL, .cpuUdsL, .cpuLdsL, .cpuDataOut, .cpuDtackL,
		.dramSelectL, .dramAddress, .dramWeL, .dramUdsL, .dramLdsL, .dramDataOut,
		.dramImage(dramMem), .errorCount, .checkCount
	);

	always #5 Clock = ~Clock; // 10 ns period

	always @(posedge Clock) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount == cycleLimit) begin
			$display("timeout: run did not finish within %0d cycles", cycleLimit);
			$display("Test failures found");
			$finish;
		end
	end

	////////////////////////////////
	// CPU bus driver
	////////////////////////////////

	task automatic busCycle(input logic [31:0] addr, input logic isWrite,
		input logic [15:0] data, input logic udsL, input logic ldsL);
		@(posedge Clock);
		#1;
		cpuAddress = addr;
		cpuWeL = !isWrite;
		cpuDataIn = data;
		cpuUdsL = udsL;
		cpuLdsL = ldsL;
		cpuAsL = 1'b0;
		@(negedge Clock);
		while (cpuDtackL) @(negedge Clock); // wait for dtack
		@(posedge Clock);
		#1;
		cpuAsL = 1'b1;
		@(negedge Clock);
		while (!cpuDtackL) @(negedge Clock); // cycle done once dtack is back high
	endtask

	////////////////////////////////
	// DRAM model
	////////////////////////////////

	task automatic serveBurst;
		int waitCycles;
		int base;
		int k;
		waitCycles = $random(seed) & 3;
		repeat (waitCycles) begin
			@(posedge Clock);
			#1;
			dramCasL = ($random(seed) & 3) != 0; // now and then a refresh
			dramRasL = dramCasL;
		end
		@(posedge Clock);
		#1;
		dramCasL = 1'b0; // read CAS, RAS high
		dramRasL = 1'b1;
		@(posedge Clock);
		#1;
		dramCasL = 1'b1;
		@(posedge Clock); // second latency cycle
		base = dramAddress[12:1];
		for (k = 0; k < `LINE_WORDS; k++) begin
			@(posedge Clock);
			#1;
			dramReadData = dramMem[base + k];
		end
		while (!dramSelectL) @(negedge Clock);
	endtask

	task automatic serveWrite;
		int waitCycles;
		int wordAddr;
		waitCycles = $random(seed) & 3;
		repeat (waitCycles) @(posedge Clock);
		@(posedge Clock);
		#1;
		wordAddr = dramAddress[12:1];
		if (!dramUdsL) dramMem[wordAddr][15:8] = dramDataOut[15:8];
		if (!dramLdsL) dramMem[wordAddr][7:0] = dramDataOut[7:0];
		dramDtackL = 1'b0; // held until select drops
		while (!dramSelectL) @(negedge Clock);
		@(posedge Clock);
		#1;
		dramDtackL = 1'b1;
	endtask

	initial begin
		int i;
		dramCasL = 1'b1;
		dramRasL = 1'b1;
		dramDtackL = 1'b1;
		dramReadData = '0;
		for (i = 0; i < 4096; i++) dramMem[i] = 16'($random(seed));
		forever begin
			@(negedge Clock);
			if (Reset_L && !dramSelectL) begin
				if (dramWeL) serveBurst();
				else serveWrite();
			end
		end
	end

	////////////////////////////////
	// test sequence
	////////////////////////////////

	initial begin
		int i;
		int tagSel;
		logic [31:0] addr;
		logic isWrite;
		logic [1:0] strobes;
		Reset_L = 1'b0;
		cpuAddress = '0;
		cpuDataIn = '0;
		cpuAsL = 1'b1;
		cpuWeL = 1'b1;
		cpuUdsL = 1'b1;
		cpuLdsL = 1'b1;
		cpuSelect = 1'b0;
		repeat (4) @(posedge Clock);
		#1;
		Reset_L = 1'b1;
		cpuSelect = 1'b1; // every access goes to DRAM space

		for (i = 0; i < 8; i++) busCycle(i * 32'h90 + ((i * 2) & 32'he), 1'b0, '0, 1'b0, 1'b0);
		check.finishTest(1, "eight lines miss after reset");

		for (i = 0; i < 8; i++) begin
			busCycle(i * 32'h90, 1'b0, '0, 1'b0, 1'b0); // tag i in set i
			busCycle(i * 32'h90 + 32'ha, 1'b0, '0, 1'b0, 1'b0);
		end
		check.finishTest(2, "rereads hit");

		busCycle(32'h124, 1'b1, 16'ha5c3, 1'b0, 1'b0);
		busCycle(32'h124, 1'b0, '0, 1'b0, 1'b0);
		busCycle(32'h1b6, 1'b1, 16'h5a3c, 1'b0, 1'b1); // upper byte only
		busCycle(32'h1b6, 1'b0, '0, 1'b0, 1'b0);
		check.finishTest(3, "write through invalidates");

		for (i = 0; i < 20; i++) begin
			tagSel = $unsigned($random(seed)) % 5;
			addr = ((16 + tagSel) << 7) | 32'h50 | (($random(seed) & 7) << 1); // set 5
			busCycle(addr, 1'b0, '0, 1'b0, 1'b0);
		end
		check.finishTest(4, "five tags in one set");

		for (i = 0; i < 40; i++) begin
			isWrite = ($random(seed) & 3) == 0;
			tagSel = $unsigned($random(seed)) % 6;
			addr = (tagSel << 7) | (($random(seed) & 1) << 4) | (($random(seed) & 7) << 1);
			strobes = $random(seed);
			if (strobes == 2'b11 || !isWrite) strobes = 2'b00;
			busCycle(addr, isWrite, 16'($random(seed)), strobes[1], strobes[0]);
		end
		check.finishTest(5, "random reads and writes");

		$display("summary: %0d of %0d transactions checked, %0d mismatches",
			checkCount, transactionCount, errorCount);
		if (errorCount == 0 && checkCount == transactionCount) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// File: testbench/cacheTop_props.sv
// bus protocol checks bound into the cache top; a violation shows up only as an assertion error
`timescale 1ns/1ps

module cacheTopProps (
	input logic Clock,
	input logic Reset_L,
	input logic cpuAsL,
	input logic cpuDtackL,
	input logic dramSelectL,
	input cachePkg::ctrlState state,
	input cachePkg::wayMask dataWeL
);

	// dtack may lag the released strobe by one cycle only
	dtackFollowsStrobe: assert property (@(posedge Clock) disable iff (!Reset_L)
		(cpuAsL && !cpuDtackL) |=> cpuDtackL)
		else $error("cpuDtackL stayed low after cpuAsL was released");

	idleLeavesDram: assert property (@(posedge Clock) disable iff (!Reset_L)
		(state == cachePkg::Idle) |-> dramSelectL)
		else $error("DRAM selected while the controller is idle");

	// data store written by the burst only
	fillOnlyInBurst: assert property (@(posedge Clock) disable iff (!Reset_L)
		(dataWeL != '1) |-> (state == cachePkg::BurstFill))
		else $error("data store written outside a burst fill");

endmodule

bind m68kCacheTop cacheTopProps props (
	.Clock, .Reset_L, .cpuAsL, .cpuDtackL, .dramSelectL,
	.state(uController.state), .dataWeL
);
